// ==== flist.f ====
+incdir+tests
hw/accel_pkg.sv
hw/operand_buffer.sv
hw/k_counter.sv
hw/compute_fsm.sv
hw/systolic_array.sv
hw/wb_csr_regs.sv
hw/accel_top.sv
tests/tb_accel_top.sv

// ==== Bender.yml ====
package:
  name: matmul_accel

sources:
  - files:
      - hw/accel_pkg.sv
      - hw/operand_buffer.sv
      - hw/k_counter.sv
      - hw/compute_fsm.sv
      - hw/systolic_array.sv
      - hw/wb_csr_regs.sv
      - hw/accel_top.sv

  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_accel_top.sv

// ==== tests/tb_accel_tasks.svh ====
// Wishbone bus tasks, reference model and directed tests
// Included in the testbench module, uses its signals and counters

// ============================================================
// Wishbone classic access
// ============================================================
task automatic bus_cycle(input logic we, input logic [WB_AW-1:0] adr,
                         input logic [31:0] wdata, output logic [31:0] rdata);
    int   waited;
    logic got_ack;
    waited  = 0;
    got_ack = 1'b0;
    rdata   = '0;
    @(posedge clk);
    i_wb <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: wdata};
    // Ack and read data are sampled mid-cycle
    while (!got_ack && waited < 20) begin
        @(negedge clk);
        waited++;
        if (o_wb.ack) begin
            got_ack = 1'b1;
            rdata   = o_wb.dat_r;
        end
    end
    @(posedge clk);
    i_wb <= '0;
    if (!got_ack) begin
        error_count++;
        $display("Slave gave no ack within 20 cycles at address 0x%02h", adr);
    end
endtask

task automatic wb_write(input logic [WB_AW-1:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, data, unused);
endtask

task automatic wb_read(input logic [WB_AW-1:0] adr, output logic [31:0] data);
    bus_cycle(1'b0, adr, '0, data);
endtask

task automatic check_value(input string name, input logic [31:0] exp,
                           input logic [31:0] got);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("MISMATCH %s expected 0x%08h got 0x%08h", name, exp, got);
    end
endtask

task automatic report_test(input string name, input int errors_before);
    test_count++;
    $display("%-20s %s", name, (error_count == errors_before) ? "ok" : "FAILED");
endtask

// ============================================================
// Operand loading, run control and reference model
// ============================================================
task automatic load_pair(input int k, input logic [15:0] act_word,
                         input logic [15:0] wgt_word);
    wb_write(WB_AW'(BASE_ACT + k), {16'h0, act_word});
    wb_write(WB_AW'(BASE_WGT + k), {16'h0, wgt_word});
    for (int n = 0; n < N_ROWS; n++) begin
        act_mem[k][n] = act_word[8*n +: 8];
    end
    for (int n = 0; n < N_COLS; n++) begin
        wgt_mem[k][n] = wgt_word[8*n +: 8];
    end
endtask

task automatic load_random(input int k_len);
    logic [31:0] act_rand;
    logic [31:0] wgt_rand;
    for (int k = 0; k < k_len; k++) begin
        act_rand = $random(seed);
        wgt_rand = $random(seed);
        load_pair(k, act_rand[15:0], wgt_rand[15:0]);
    end
endtask

task automatic start_run(input int k_len);
    wb_write(REG_KLEN, k_len);
    wb_write(REG_CTRL, 32'h1);
endtask

// C[i][j] is the sum of A[k][i] * B[k][j], signed, wrapping at 32 bits
task automatic compute_expected(input int k_len);
    int acc;
    for (int i = 0; i < N_ROWS; i++) begin
        for (int j = 0; j < N_COLS; j++) begin
            acc = 0;
            for (int k = 0; k < k_len; k++) begin
                acc = acc + int'(act_mem[k][i]) * int'(wgt_mem[k][j]);
            end
            expected[i*N_COLS+j] = acc;
        end
    end
endtask

task automatic wait_done(output logic busy_seen);
    logic [31:0] status;
    int          polls;
    logic        finished;
    busy_seen = 1'b0;
    polls     = 0;
    finished  = 1'b0;
    while (!finished && polls < 200) begin
        wb_read(REG_STATUS, status);
        polls++;
        if (status[0]) begin
            busy_seen = 1'b1;
        end
        if (status[1] && !status[0]) begin
            finished = 1'b1;
        end
    end
    if (!finished) begin
        error_count++;
        $display("Run did not finish within 200 status polls");
    end
endtask

task automatic check_results();
    logic [31:0] got;
    for (int idx = 0; idx < N_ROWS * N_COLS; idx++) begin
        wb_read(WB_AW'(BASE_RES + idx), got);
        check_value($sformatf("C%0d%0d", idx / N_COLS, idx % N_COLS), expected[idx], got);
    end
endtask

// ============================================================
// Directed tests
// ============================================================
task automatic check_after_reset();
    int          start_errors;
    logic [31:0] value;
    start_errors = error_count;
    wb_read(REG_STATUS, value);
    check_value("status", 32'h0, value);
    wb_read(REG_KLEN, value);
    check_value("k_len", 32'h0, value);
    compute_expected(0);
    check_results();
    report_test("reset state", start_errors);
endtask

task automatic run_fixed_k3();
    int          start_errors;
    logic        busy_seen;
    logic [31:0] value;
    start_errors = error_count;
    load_pair(0, 16'h0001, 16'h0003);
    load_pair(1, 16'h0100, 16'h0500);
    // Negative lanes give negative products
    load_pair(2, 16'h02FF, 16'h04FE);
    start_run(3);
    wait_done(busy_seen);
    if (!busy_seen) begin
        error_count++;
        $display("Busy was never seen during the K=3 run");
    end
    wb_read(REG_STATUS, value);
    check_value("status", 32'h2, value);
    compute_expected(3);
    check_results();
    report_test("fixed K=3", start_errors);
endtask

task automatic run_random_k16();
    int   start_errors;
    logic busy_seen;
    start_errors = error_count;
    load_random(16);
    start_run(16);
    wait_done(busy_seen);
    compute_expected(16);
    check_results();
    report_test("random K=16", start_errors);
endtask

task automatic run_empty_k();
    int          start_errors;
    logic        busy_seen;
    logic [31:0] value;
    start_errors = error_count;
    start_run(0);
    wait_done(busy_seen);
    wb_read(REG_STATUS, value);
    check_value("status", 32'h2, value);
    compute_expected(0);
    check_results();
    report_test("empty K", start_errors);
endtask

task automatic ignore_busy_writes();
    int          start_errors;
    logic        busy_seen;
    logic [31:0] value;
    start_errors = error_count;
    load_random(8);
    compute_expected(8);
    start_run(8);
    // Entries still ahead of the feed, so accepted writes would change the sums
    wb_write(WB_AW'(BASE_ACT + 7), 32'h7F7F);
    wb_write(WB_AW'(BASE_WGT + 6), 32'h8080);
    wb_write(REG_KLEN, 32'd3);
    wb_write(REG_CTRL, 32'h1);
    wait_done(busy_seen);
    wb_read(REG_KLEN, value);
    check_value("k_len", 32'd8, value);
    wb_read(REG_STATUS, value);
    check_value("status", 32'h2, value);
    check_results();
    report_test("writes while busy", start_errors);
endtask

task automatic run_back_to_back();
    int          start_errors;
    logic        busy_seen;
    logic [31:0] value;
    start_errors = error_count;
    load_random(5);
    start_run(5);
    wait_done(busy_seen);
    compute_expected(5);
    check_results();
    load_random(6);
    start_run(6);
    wb_read(REG_STATUS, value);
    if (value[1]) begin
        error_count++;
        $display("Done bit still set right after the second start");
    end
    wait_done(busy_seen);
    compute_expected(6);
    check_results();
    report_test("back-to-back runs", start_errors);
endtask

// ==== tests/tb_accel_top.sv ====
// Testbench for the 2x2 matrix-multiply accelerator
// Drives the Wishbone port through the directed tests and prints a summary
`timescale 1ns/1ps

module tb_accel_top;
    import accel_pkg::*;

    logic    clk;
    logic    rst_n;
    wb_req_t i_wb;
    wb_rsp_t o_wb;

    int     error_count;
    int     check_count;
    int     test_count;
    integer seed;

    // Host-side copy of the operands, input to the reference model
    logic signed [DATA_W-1:0] act_mem [BUF_DEPTH][N_ROWS];
    logic signed [DATA_W-1:0] wgt_mem [BUF_DEPTH][N_COLS];
    logic [ACC_W-1:0]         expected [N_ROWS*N_COLS];

    accel_top dut (
        .clk   (clk),
        .rst_n (rst_n),
        .i_wb  (i_wb),
        .o_wb  (o_wb)
    );

    `include "tb_accel_tasks.svh"

    // 100 ns clock
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        error_count = 0;
        check_count = 0;
        test_count  = 0;
        seed        = 32'h452f2a1d;
        rst_n       = 1'b0;
        i_wb        = '0;

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        check_after_reset();
        run_fixed_k3();
        run_random_k16();
        run_empty_k();
        ignore_busy_writes();
        run_back_to_back();

        $display("Summary: %0d tests, %0d checks, %0d failures",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== hw/accel_top.sv ====
// Top level of the matrix-multiply accelerator
// The host loads operands, sets K and starts a run over the Wishbone port
`timescale 1ns/1ps

module accel_top (
    input  logic               clk,
    input  logic               rst_n,
    input  accel_pkg::wb_req_t i_wb,
    output accel_pkg::wb_rsp_t o_wb
);
    import accel_pkg::*;

    // Host side
    logic              start;
    logic [KLEN_W-1:0] k_len;
    logic              act_we;
    logic              wgt_we;
    logic [BUF_AW-1:0] buf_waddr;
    act_vec_t          act_wdata;
    wgt_vec_t          wgt_wdata;
    logic              busy;
    logic              done;
    result_t           results;

    // Sequencer side
    logic              cnt_load;
    logic [KLEN_W-1:0] cnt_limit;
    logic              cnt_run;
    logic [BUF_AW-1:0] cnt_value;
    logic              cnt_last;
    logic              rd_en;
    logic [BUF_AW-1:0] raddr;
    array_ctrl_t       array_ctrl;
    act_vec_t          act_rdata;
    wgt_vec_t          wgt_rdata;

    wb_csr_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_wb        (i_wb),
        .o_wb        (o_wb),
        .i_busy      (busy),
        .i_done      (done),
        .i_results   (results),
        .o_start     (start),
        .o_k_len     (k_len),
        .o_act_we    (act_we),
        .o_wgt_we    (wgt_we),
        .o_buf_waddr (buf_waddr),
        .o_act_wdata (act_wdata),
        .o_wgt_wdata (wgt_wdata)
    );

    // Both buffers are read at the same address in lockstep
    operand_buffer #(.T_PAYLOAD(act_vec_t)) u_act_buf (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_we    (act_we),
        .i_waddr (buf_waddr),
        .i_wdata (act_wdata),
        .i_rd_en (rd_en),
        .i_raddr (raddr),
        .o_rdata (act_rdata)
    );

    operand_buffer #(.T_PAYLOAD(wgt_vec_t)) u_wgt_buf (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_we    (wgt_we),
        .i_waddr (buf_waddr),
        .i_wdata (wgt_wdata),
        .i_rd_en (rd_en),
        .i_raddr (raddr),
        .o_rdata (wgt_rdata)
    );

    k_counter u_counter (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_load  (cnt_load),
        .i_limit (cnt_limit),
        .i_run   (cnt_run),
        .o_count (cnt_value),
        .o_last  (cnt_last)
    );

    compute_fsm u_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_start      (start),
        .i_k_len      (k_len),
        .i_cnt_last   (cnt_last),
        .i_cnt_value  (cnt_value),
        .o_cnt_load   (cnt_load),
        .o_cnt_limit  (cnt_limit),
        .o_cnt_run    (cnt_run),
        .o_rd_en      (rd_en),
        .o_raddr      (raddr),
        .o_array_ctrl (array_ctrl),
        .o_busy       (busy),
        .o_done       (done)
    );

    systolic_array u_array (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_ctrl    (array_ctrl),
        .i_act     (act_rdata),
        .i_wgt     (wgt_rdata),
        .o_results (results)
    );

endmodule

// ==== hw/wb_csr_regs.sv ====
// Wishbone classic slave with the control, status and K registers
// Also routes operand buffer writes and result reads for the host
`timescale 1ns/1ps

module wb_csr_regs (
    input  logic                         clk,
    input  logic                         rst_n,
    input  accel_pkg::wb_req_t           i_wb,
    output accel_pkg::wb_rsp_t           o_wb,
    input  logic                         i_busy,
    input  logic                         i_done,
    input  accel_pkg::result_t           i_results,
    output logic                         o_start,
    output logic [accel_pkg::KLEN_W-1:0] o_k_len,
    output logic                         o_act_we,
    output logic                         o_wgt_we,
    output logic [accel_pkg::BUF_AW-1:0] o_buf_waddr,
    output accel_pkg::act_vec_t          o_act_wdata,
    output accel_pkg::wgt_vec_t          o_wgt_wdata
);
    import accel_pkg::*;

    localparam int RES_AW = $clog2(N_ROWS * N_COLS);

    logic              ack_q;
    logic [31:0]       dat_r_q;
    logic              done_q;
    logic [KLEN_W-1:0] k_len_q;
    logic [KLEN_W-1:0] k_len_sat;
    logic              access;
    logic              wr_ack;
    logic              wr_open;
    logic              is_ctrl;
    logic              is_status;
    logic              is_klen;
    logic              is_act;
    logic              is_wgt;
    logic              is_res;
    logic [31:0]       rd_mux;

    // ============================================================
    // Handshake, ack one cycle after a fresh request
    // ============================================================
    assign access  = i_wb.cyc && i_wb.stb && !ack_q;
    assign wr_ack  = ack_q && i_wb.cyc && i_wb.stb && i_wb.we;
    // Writes other than status reads are dropped during a run
    assign wr_open = wr_ack && !i_busy;

    // Address decode
    assign is_ctrl   = (i_wb.adr == REG_CTRL);
    assign is_status = (i_wb.adr == REG_STATUS);
    assign is_klen   = (i_wb.adr == REG_KLEN);
    assign is_act    = (i_wb.adr[WB_AW-1:BUF_AW] == BASE_ACT[WB_AW-1:BUF_AW]);
    assign is_wgt    = (i_wb.adr[WB_AW-1:BUF_AW] == BASE_WGT[WB_AW-1:BUF_AW]);
    assign is_res    = (i_wb.adr[WB_AW-1:RES_AW] == BASE_RES[WB_AW-1:RES_AW]);

    // K larger than the buffer depth is clipped
    assign k_len_sat = (i_wb.dat_w > BUF_DEPTH) ? KLEN_W'(BUF_DEPTH)
                                                : i_wb.dat_w[KLEN_W-1:0];

    always_comb begin
        rd_mux = '0;
        if (is_status) begin
            rd_mux[1:0] = {done_q, i_busy};
        end else if (is_klen) begin
            rd_mux[KLEN_W-1:0] = k_len_q;
        end else if (is_res) begin
            rd_mux = i_results[i_wb.adr[RES_AW-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q   <= 1'b0;
            done_q  <= 1'b0;
            k_len_q <= '0;
        end else begin
            ack_q <= access;
            if (o_start) begin
                done_q <= 1'b0;
            end else if (i_done) begin
                done_q <= 1'b1;
            end
            if (wr_open && is_klen) begin
                k_len_q <= k_len_sat;
            end
        end
    end

    // Read data for the ack cycle
    always_ff @(posedge clk) begin
        dat_r_q <= (access && !i_wb.we) ? rd_mux : '0;
    end

    assign o_wb = '{ack: ack_q, dat_r: dat_r_q};

    assign o_start     = wr_open && is_ctrl && i_wb.dat_w[0];
    assign o_k_len     = k_len_q;
    assign o_act_we    = wr_open && is_act;
    assign o_wgt_we    = wr_open && is_wgt;
    assign o_buf_waddr = i_wb.adr[BUF_AW-1:0];
    assign o_act_wdata = act_vec_t'(i_wb.dat_w[$bits(act_vec_t)-1:0]);
    assign o_wgt_wdata = wgt_vec_t'(i_wb.dat_w[$bits(wgt_vec_t)-1:0]);

    // Every ack answers a strobe that the host still holds
    ack_after_stb: assert property (@(posedge clk) disable iff (!rst_n)
        o_wb.ack |-> $past(i_wb.stb) && i_wb.cyc && i_wb.stb);

endmodule

// ==== hw/systolic_array.sv ====
// Output-stationary 2x2 systolic array of signed 8-bit MAC cells
// Activations move right, weights move down, sums stay in the cells
`timescale 1ns/1ps

module systolic_array (
    input  logic                   clk,
    input  logic                   rst_n,
    input  accel_pkg::array_ctrl_t i_ctrl,
    input  accel_pkg::act_vec_t    i_act,
    input  accel_pkg::wgt_vec_t    i_wgt,
    output accel_pkg::result_t     o_results
);
    import accel_pkg::*;

    // One stage for the buffer read, then up to i+j stages to reach a cell
    localparam int VDEPTH = N_ROWS + N_COLS - 1;

    logic [VDEPTH-1:0] valid_pipe;
    elem_t             act_skew [N_ROWS][N_ROWS];
    elem_t             wgt_skew [N_COLS][N_COLS];
    elem_t             act_op   [N_ROWS][N_COLS];
    elem_t             wgt_op   [N_ROWS][N_COLS];
    logic [ACC_W-1:0]  acc      [N_ROWS][N_COLS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[VDEPTH-2:0], i_ctrl.feed_valid};
        end
    end

    // ============================================================
    // Input skew, row i delayed by i and column j by j
    // ============================================================
    for (genvar r = 0; r < N_ROWS; r++) begin : g_act_skew
        assign act_skew[r][0] = i_act.lane[r];
        for (genvar s = 1; s <= r; s++) begin : g_stage
            always_ff @(posedge clk) begin
                if (i_ctrl.acc_en) begin
                    act_skew[r][s] <= act_skew[r][s-1];
                end
            end
        end
    end

    for (genvar c = 0; c < N_COLS; c++) begin : g_wgt_skew
        assign wgt_skew[c][0] = i_wgt.lane[c];
        for (genvar s = 1; s <= c; s++) begin : g_stage
            always_ff @(posedge clk) begin
                if (i_ctrl.acc_en) begin
                    wgt_skew[c][s] <= wgt_skew[c][s-1];
                end
            end
        end
    end

    // ============================================================
    // MAC cells
    // ============================================================
    for (genvar i = 0; i < N_ROWS; i++) begin : g_row
        for (genvar j = 0; j < N_COLS; j++) begin : g_col
            logic signed [2*DATA_W-1:0] prod;

            if (j == 0) begin : g_act_edge
                assign act_op[i][j] = act_skew[i][i];
            end else begin : g_act_pass
                always_ff @(posedge clk) begin
                    if (i_ctrl.acc_en) begin
                        act_op[i][j] <= act_op[i][j-1];
                    end
                end
            end

            if (i == 0) begin : g_wgt_edge
                assign wgt_op[i][j] = wgt_skew[j][j];
            end else begin : g_wgt_pass
                always_ff @(posedge clk) begin
                    if (i_ctrl.acc_en) begin
                        wgt_op[i][j] <= wgt_op[i-1][j];
                    end
                end
            end

            assign prod = act_op[i][j] * wgt_op[i][j];

            // Sum wraps at ACC_W bits
            always_ff @(posedge clk) begin
                if (!rst_n || i_ctrl.clr) begin
                    acc[i][j] <= '0;
                end else if (i_ctrl.acc_en && valid_pipe[i+j]) begin
                    acc[i][j] <= acc[i][j] + {{(ACC_W-2*DATA_W){prod[2*DATA_W-1]}}, prod};
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < N_ROWS; i++) begin
            for (int j = 0; j < N_COLS; j++) begin
                o_results[i*N_COLS+j] = acc[i][j];
            end
        end
    end

endmodule

// ==== hw/compute_fsm.sv ====
// Run sequencer: clear, feed K operand pairs, drain the array, signal done
// Steers the counter, the buffer reads and the array control
`timescale 1ns/1ps

module compute_fsm (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         i_start,
    input  logic [accel_pkg::KLEN_W-1:0] i_k_len,
    input  logic                         i_cnt_last,
    input  logic [accel_pkg::BUF_AW-1:0] i_cnt_value,
    output logic                         o_cnt_load,
    output logic [accel_pkg::KLEN_W-1:0] o_cnt_limit,
    output logic                         o_cnt_run,
    output logic                         o_rd_en,
    output logic [accel_pkg::BUF_AW-1:0] o_raddr,
    output accel_pkg::array_ctrl_t       o_array_ctrl,
    output logic                         o_busy,
    output logic                         o_done
);
    import accel_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,
        ST_CLEAR = 3'd1,
        ST_FEED  = 3'd2,
        ST_DRAIN = 3'd3,
        ST_DONE  = 3'd4
    } state_t;

    state_t state_q;
    state_t state_d;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d      = state_q;
        o_cnt_load   = 1'b0;
        o_cnt_limit  = '0;
        o_cnt_run    = 1'b0;
        o_rd_en      = 1'b0;
        o_array_ctrl = '0;
        case (state_q)
            ST_IDLE: begin
                if (i_start) begin
                    state_d = ST_CLEAR;
                end
            end
            ST_CLEAR: begin
                o_array_ctrl.clr = 1'b1;
                o_cnt_load       = 1'b1;
                // Empty K goes straight to the drain count
                if (i_k_len == '0) begin
                    o_cnt_limit = KLEN_W'(DRAIN_CYCLES);
                    state_d     = ST_DRAIN;
                end else begin
                    o_cnt_limit = i_k_len;
                    state_d     = ST_FEED;
                end
            end
            ST_FEED: begin
                o_rd_en                 = 1'b1;
                o_cnt_run               = 1'b1;
                o_array_ctrl.feed_valid = 1'b1;
                o_array_ctrl.acc_en     = 1'b1;
                if (i_cnt_last) begin
                    o_cnt_load  = 1'b1;
                    o_cnt_limit = KLEN_W'(DRAIN_CYCLES);
                    state_d     = ST_DRAIN;
                end
            end
            ST_DRAIN: begin
                o_cnt_run           = 1'b1;
                o_array_ctrl.acc_en = 1'b1;
                if (i_cnt_last) begin
                    state_d = ST_DONE;
                end
            end
            ST_DONE: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // Buffer address follows the counter
    assign o_raddr = i_cnt_value;
    assign o_busy  = (state_q != ST_IDLE);
    assign o_done  = (state_q == ST_DONE);

    // Legal state, and a start only ever arrives while idle
    state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        (state_q inside {ST_IDLE, ST_CLEAR, ST_FEED, ST_DRAIN, ST_DONE})
        && (!i_start || state_q == ST_IDLE));

endmodule

// ==== hw/k_counter.sv ====
// Loadable up-counter for the feed and drain phases of the sequencer
`timescale 1ns/1ps

module k_counter (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         i_load,
    input  logic [accel_pkg::KLEN_W-1:0] i_limit,
    input  logic                         i_run,
    output logic [accel_pkg::BUF_AW-1:0] o_count,
    output logic                         o_last
);
    import accel_pkg::*;

    logic [KLEN_W-1:0] limit_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_count <= '0;
            limit_q <= '0;
        end else if (i_load) begin
            o_count <= '0;
            limit_q <= i_limit;
        end else if (i_run && !o_last) begin
            o_count <= o_count + 1'b1;
        end
    end

    // Final count, or nothing to count at all
    assign o_last = (limit_q == '0) || (KLEN_W'(o_count) == limit_q - 1'b1);

    run_below_limit: assert property (@(posedge clk) disable iff (!rst_n)
        i_run |-> (KLEN_W'(o_count) < limit_q));

endmodule

// ==== hw/operand_buffer.sv ====
// Operand memory with one write port and one registered read port
// Instantiated once per operand type
`timescale 1ns/1ps

module operand_buffer #(
    parameter type T_PAYLOAD = accel_pkg::act_vec_t
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         i_we,
    input  logic [accel_pkg::BUF_AW-1:0] i_waddr,
    input  T_PAYLOAD                     i_wdata,
    input  logic                         i_rd_en,
    input  logic [accel_pkg::BUF_AW-1:0] i_raddr,
    output T_PAYLOAD                     o_rdata
);
    import accel_pkg::*;

    T_PAYLOAD mem [BUF_DEPTH];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // Read register holds its value between reads
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_rdata <= '0;
        end else if (i_rd_en) begin
            o_rdata <= mem[i_raddr];
        end
    end

endmodule

// ==== hw/accel_pkg.sv ====
// Shared geometry, register map and bus types of the 2x2 matrix-multiply accelerator
// Every RTL module imports what it needs from here
package accel_pkg;

    // ============================================================
    // Array geometry and widths
    // ============================================================
    localparam int N_ROWS       = 2;
    localparam int N_COLS       = 2;
    localparam int DATA_W       = 8;
    localparam int ACC_W        = 32;
    localparam int BUF_DEPTH    = 16;
    localparam int BUF_AW       = 4;
    localparam int KLEN_W       = 5;
    // Buffer read register, one skew stage and one pass stage, then the MAC
    localparam int DRAIN_CYCLES = 4;

    // ============================================================
    // Register map (word addresses)
    // ============================================================
    localparam int WB_AW = 8;

    localparam logic [WB_AW-1:0] REG_CTRL   = 8'h00;
    localparam logic [WB_AW-1:0] REG_STATUS = 8'h01;
    localparam logic [WB_AW-1:0] REG_KLEN   = 8'h02;
    localparam logic [WB_AW-1:0] BASE_ACT   = 8'h10;
    localparam logic [WB_AW-1:0] BASE_WGT   = 8'h20;
    localparam logic [WB_AW-1:0] BASE_RES   = 8'h30;

    // Operand element, lane i sits in bits 8i+7:8i
    typedef logic signed [DATA_W-1:0] elem_t;

    typedef struct packed {
        elem_t [N_ROWS-1:0] lane;
    } act_vec_t;

    typedef struct packed {
        elem_t [N_COLS-1:0] lane;
    } wgt_vec_t;

    // Row-major accumulators, C[i][j] at index i*N_COLS+j
    typedef logic [N_ROWS*N_COLS-1:0][ACC_W-1:0] result_t;

    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [WB_AW-1:0] adr;
        logic [31:0]      dat_w;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat_r;
    } wb_rsp_t;

    typedef struct packed {
        logic clr;
        logic feed_valid;
        logic acc_en;
    } array_ctrl_t;

endpackage
